/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_dbg_spr_top
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
src/dbg_pkg.sv
src/dbg_burst_engine.sv
src/dbg_spr_biu.sv
src/cpu_spr_file.sv
src/dbg_spr_top.sv
tb/tb_dbg_spr_top.sv

/* src/cpu_spr_file.sv */
// CPU SPR register file with address-selected wait states before acknowledge
`timescale 1ns/1ps

module cpu_spr_file (
  input  logic                        cpu_clk_i,
  input  logic                        rst_i,
  input  logic [dbg_pkg::ADDR_W-1:0]  spr_addr_i,
  input  logic [dbg_pkg::DATA_W-1:0]  spr_data_i,
  output logic [dbg_pkg::DATA_W-1:0]  spr_data_o,
  input  logic                        spr_stb_i,
  input  logic                        spr_we_i,
  output logic                        spr_ack_o
);

  logic [dbg_pkg::DATA_W-1:0]    regs_q [dbg_pkg::SPR_DEPTH];
  logic [dbg_pkg::SPR_IDX_W-1:0] idx;       // Address mod depth
  logic [dbg_pkg::WAIT_W-1:0]    wait_sel;  // Wait cycles from address
  logic [dbg_pkg::WAIT_W-1:0]    cnt_q;     // Cycles left before ack
  logic                          active_q;  // Waiting access

  assign idx      = spr_addr_i[dbg_pkg::SPR_IDX_W-1:0];
  assign wait_sel = spr_addr_i[dbg_pkg::WAIT_LSB +: dbg_pkg::WAIT_W];

  // Zero-wait access acks in the strobe's first cycle
  assign spr_ack_o = active_q ? (cnt_q == '0) : (spr_stb_i && (wait_sel == '0));

  assign spr_data_o = regs_q[idx];  // Combinational read

  ///////////////////////////////
  // Wait-state counter
  ///////////////////////////////

  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (!active_q) begin
      if (spr_stb_i && (wait_sel != '0)) begin
        active_q <= 1'b1;
        cnt_q    <= wait_sel - 1'b1;  // Rise cycle counts as one
      end
    end else if (cnt_q == '0) begin
      active_q <= 1'b0;  // Ack cycle
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  ///////////////////////////////
  // Register array
  ///////////////////////////////

  // All SPRs read zero after reset
  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < dbg_pkg::SPR_DEPTH; i++) begin
        regs_q[i] <= '0;
      end
    end else if (spr_ack_o && spr_we_i) begin
      regs_q[idx] <= spr_data_i;  // Write lands on ack
    end
  end

  // Counter path relies on the master holding stb until ack
  a_ack_stb: assert property (
    @(posedge cpu_clk_i) disable iff (rst_i)
    spr_ack_o |-> spr_stb_i
  );

endmodule

/* src/dbg_burst_engine.sv */
// Debug burst engine that splits a burst command into single-word BIU accesses
`timescale 1ns/1ps

module dbg_burst_engine (
  input  logic                        tck_i,
  input  logic                        rst_i,

  // Host command port
  input  logic                        cmd_stb_i,
  input  logic [dbg_pkg::ADDR_W-1:0]  cmd_addr_i,
  input  logic                        cmd_wr_i,
  input  logic [dbg_pkg::LEN_W-1:0]   cmd_len_i,
  input  logic [dbg_pkg::DATA_W-1:0]  wdata_i,     // Held until word_done_o
  output logic                        busy_o,
  output logic                        word_done_o,
  output logic                        done_o,
  output logic [dbg_pkg::DATA_W-1:0]  rdata_o,
  output logic                        rdata_stb_o,

  // BIU strobe interface
  output logic                        biu_strobe_o,
  output logic [dbg_pkg::ADDR_W-1:0]  biu_addr_o,
  output logic [dbg_pkg::DATA_W-1:0]  biu_data_o,
  output logic                        biu_rd_wrn_o,
  input  logic [dbg_pkg::DATA_W-1:0]  biu_data_i,
  input  logic                        biu_rdy_i
);

  dbg_pkg::eng_state_e         state_q;
  logic [dbg_pkg::ADDR_W-1:0]  addr_q;   // Running word address
  logic [dbg_pkg::LEN_W-1:0]   cnt_q;    // Words left after current one
  logic                        wr_q;     // Burst direction
  logic                        cmd_go;   // Command accepted this cycle
  logic                        word_end; // Current access finished
  logic                        last_word;

  ///////////////////////////////
  // Strobe side
  ///////////////////////////////

  assign cmd_go    = (state_q == dbg_pkg::ENG_IDLE) && cmd_stb_i;  // Ignored while busy
  assign word_end  = (state_q == dbg_pkg::ENG_WAIT) && biu_rdy_i;  // Ready back high
  assign last_word = (cnt_q == '0);

  // One strobe per word only with ready up
  assign biu_strobe_o = (state_q == dbg_pkg::ENG_ISSUE) && biu_rdy_i;
  assign biu_addr_o   = addr_q;
  assign biu_rd_wrn_o = ~wr_q;
  assign biu_data_o   = wdata_i;  // Host keeps it stable for the word

  assign busy_o = (state_q != dbg_pkg::ENG_IDLE);

  ///////////////////////////////
  // Sequencer
  ///////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q     <= dbg_pkg::ENG_IDLE;
      cnt_q       <= '0;
      word_done_o <= 1'b0;
      rdata_stb_o <= 1'b0;
      done_o      <= 1'b0;
    end else begin
      // Pulses default low
      word_done_o <= 1'b0;
      rdata_stb_o <= 1'b0;
      done_o      <= 1'b0;

      case (state_q)
        dbg_pkg::ENG_IDLE: begin
          if (cmd_go) begin
            cnt_q   <= cmd_len_i;          // Encoded n-1
            state_q <= dbg_pkg::ENG_ISSUE;
          end
        end
        dbg_pkg::ENG_ISSUE: begin
          if (biu_strobe_o) begin
            state_q <= dbg_pkg::ENG_WAIT;  // BIU drops ready next cycle
          end
        end
        dbg_pkg::ENG_WAIT: begin
          if (word_end) begin
            word_done_o <= 1'b1;
            rdata_stb_o <= ~wr_q;          // Read word on rdata_o now
            if (last_word) begin
              done_o  <= 1'b1;
              state_q <= dbg_pkg::ENG_IDLE;
            end else begin
              cnt_q   <= cnt_q - 1'b1;
              state_q <= dbg_pkg::ENG_ISSUE;
            end
          end
        end
        default: state_q <= dbg_pkg::ENG_IDLE;
      endcase
    end
  end

  // Address and direction loaded per command and stepped per word
  always_ff @(posedge tck_i) begin
    if (cmd_go) begin
      addr_q <= cmd_addr_i;
      wr_q   <= cmd_wr_i;
    end else if (word_end && !last_word) begin
      addr_q <= addr_q + 1'b1;  // Next word
    end
  end

  // Read data valid once ready is back
  always_ff @(posedge tck_i) begin
    if (word_end && !wr_q) begin
      rdata_o <= biu_data_i;
    end
  end

  ///////////////////////////////
  // Checks
  ///////////////////////////////

  // BIU takes every strobe and drops ready in the next cycle
  a_strobe_rdy: assert property (
    @(posedge tck_i) disable iff (rst_i)
    biu_strobe_o |=> !biu_rdy_i
  );

endmodule

/* src/dbg_pkg.sv */
// Debug SPR path shared definitions for widths, SPR file geometry and FSM encodings
package dbg_pkg;

  ///////////////////////////////
  // Bus widths
  ///////////////////////////////

  localparam int DATA_W = 32;  // SPR data word
  localparam int ADDR_W = 32;  // SPR address
  localparam int LEN_W  = 4;   // Burst count encoded as words minus one

  ///////////////////////////////
  // SPR file geometry
  ///////////////////////////////

  localparam int SPR_DEPTH = 64;                  // Registers in the file
  localparam int SPR_IDX_W = $clog2(SPR_DEPTH);   // Index = addr mod depth

  // Wait-state field inside the address
  localparam int WAIT_LSB = 0;
  localparam int WAIT_W   = 2;  // 0..3 wait cycles

  ///////////////////////////////
  // FSM encodings
  ///////////////////////////////

  // Burst engine in tck domain
  typedef enum logic [1:0] {
    ENG_IDLE  = 2'd0,  // Waiting for a command
    ENG_ISSUE = 2'd1,  // Strobe pending until ready
    ENG_WAIT  = 2'd2   // Access in flight
  } eng_state_e;

  // BIU bus side in cpu domain
  typedef enum logic {
    BIU_IDLE = 1'b0,
    BIU_XFER = 1'b1  // Multi-cycle access with stb held
  } biu_state_e;

endpackage

/* src/dbg_spr_biu.sv */
// Debug SPR bus interface unit moving single accesses from the tck clock to the CPU clock
`timescale 1ns/1ps

module dbg_spr_biu (
  // Debug side in tck domain
  input  logic                        tck_i,
  input  logic                        rst_i,
  input  logic [dbg_pkg::DATA_W-1:0]  data_i,
  output logic [dbg_pkg::DATA_W-1:0]  data_o,
  input  logic [dbg_pkg::ADDR_W-1:0]  addr_i,
  input  logic                        strobe_i,
  input  logic                        rd_wrn_i,
  output logic                        rdy_o,

  // SPR bus side in cpu domain
  input  logic                        cpu_clk_i,
  output logic [dbg_pkg::ADDR_W-1:0]  cpu_addr_o,
  input  logic [dbg_pkg::DATA_W-1:0]  cpu_data_i,
  output logic [dbg_pkg::DATA_W-1:0]  cpu_data_o,
  output logic                        cpu_stb_o,
  output logic                        cpu_we_o,
  input  logic                        cpu_ack_i
);

  // Request registers in tck domain stay stable while rdy_o low
  logic [dbg_pkg::ADDR_W-1:0] addr_q;
  logic [dbg_pkg::DATA_W-1:0] wdata_q;  // Debug to CPU
  logic                       wr_q;

  // Read data in cpu domain
  logic [dbg_pkg::DATA_W-1:0] rdata_q;  // CPU to debug

  // Toggle strobes with one edge per access
  logic str_tgl_q;  // tck -> cpu
  logic rdy_tgl_q;  // cpu -> tck

  // Synchronizers of two flops plus edge register
  logic rdy_ff1_q, rdy_ff2_q, rdy_ff3_q;  // In tck domain
  logic str_ff1_q, str_ff2_q, str_ff3_q;  // In cpu domain

  logic accept;        // Strobe taken in tck domain
  logic start_toggle;  // New access arrived in cpu domain
  logic ack_taken;     // Access ends this cycle
  logic rdata_en;

  dbg_pkg::biu_state_e state_q;
  dbg_pkg::biu_state_e state_d;

  ///////////////////////////////
  // tck domain
  ///////////////////////////////

  assign accept = strobe_i && rdy_o;  // Strobe ignored while busy

  // Latch request
  always_ff @(posedge tck_i) begin
    if (accept) begin
      addr_q <= addr_i;
      wr_q   <= ~rd_wrn_i;
      if (!rd_wrn_i) begin
        wdata_q <= data_i;  // Write data only
      end
    end
  end

  // Start toggle toward cpu domain
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      str_tgl_q <= 1'b0;
    end else if (accept) begin
      str_tgl_q <= ~str_tgl_q;
    end
  end

  // Ready up after reset, down on accept, up again on returned toggle
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      rdy_ff1_q <= 1'b0;
      rdy_ff2_q <= 1'b0;
      rdy_ff3_q <= 1'b0;
      rdy_o     <= 1'b1;
    end else begin
      rdy_ff1_q <= rdy_tgl_q;  // Metastability stage
      rdy_ff2_q <= rdy_ff1_q;
      rdy_ff3_q <= rdy_ff2_q;  // Edge detect
      if (accept) begin
        rdy_o <= 1'b0;
      end else if (rdy_ff2_q != rdy_ff3_q) begin
        rdy_o <= 1'b1;
      end
    end
  end

  // Request goes straight out and is held by the ready handshake
  assign cpu_addr_o = addr_q;
  assign cpu_data_o = wdata_q;
  assign cpu_we_o   = wr_q;
  assign data_o     = rdata_q;  // Settled well before rdy_o rises

  ///////////////////////////////
  // cpu domain
  ///////////////////////////////

  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      str_ff1_q <= 1'b0;
      str_ff2_q <= 1'b0;
      str_ff3_q <= 1'b0;
    end else begin
      str_ff1_q <= str_tgl_q;
      str_ff2_q <= str_ff1_q;
      str_ff3_q <= str_ff2_q;
    end
  end

  assign start_toggle = (str_ff2_q != str_ff3_q);

  // Bus FSM is basically an in-progress bit
  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= dbg_pkg::BIU_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      dbg_pkg::BIU_IDLE: begin
        if (start_toggle && !cpu_ack_i) begin
          state_d = dbg_pkg::BIU_XFER;  // Single-cycle ack stays here
        end
      end
      dbg_pkg::BIU_XFER: begin
        if (cpu_ack_i) begin
          state_d = dbg_pkg::BIU_IDLE;
        end
      end
      default: state_d = dbg_pkg::BIU_IDLE;
    endcase
  end

  // Strobe from the toggle edge is held until ack
  assign cpu_stb_o = (state_q == dbg_pkg::BIU_XFER) || start_toggle;
  assign ack_taken = cpu_stb_o && cpu_ack_i;
  assign rdata_en  = ack_taken && !wr_q;

  always_ff @(posedge cpu_clk_i) begin
    if (rdata_en) begin
      rdata_q <= cpu_data_i;
    end
  end

  // Ready toggle back to tck
  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      rdy_tgl_q <= 1'b0;
    end else if (ack_taken) begin
      rdy_tgl_q <= ~rdy_tgl_q;
    end
  end

  // Strobe held across wait states
  a_stb_hold: assert property (
    @(posedge cpu_clk_i) disable iff (rst_i)
    cpu_stb_o && !cpu_ack_i |=> cpu_stb_o
  );

endmodule

/* src/dbg_spr_top.sv */
// Debug-to-SPR path top with burst engine, clock-crossing BIU and SPR file
`timescale 1ns/1ps

module dbg_spr_top (
  input  logic                        tck_i,
  input  logic                        cpu_clk_i,
  input  logic                        rst_i,

  // Host command port in tck domain
  input  logic                        cmd_stb_i,
  input  logic [dbg_pkg::ADDR_W-1:0]  cmd_addr_i,
  input  logic                        cmd_wr_i,
  input  logic [dbg_pkg::LEN_W-1:0]   cmd_len_i,
  input  logic [dbg_pkg::DATA_W-1:0]  wdata_i,
  output logic                        busy_o,
  output logic                        word_done_o,
  output logic                        done_o,
  output logic [dbg_pkg::DATA_W-1:0]  rdata_o,
  output logic                        rdata_stb_o
);

  // Engine to BIU in tck domain
  logic                       biu_strobe;
  logic [dbg_pkg::ADDR_W-1:0] biu_addr;
  logic [dbg_pkg::DATA_W-1:0] biu_wdata;
  logic [dbg_pkg::DATA_W-1:0] biu_rdata;
  logic                       biu_rd_wrn;
  logic                       biu_rdy;

  // BIU to SPR file in cpu domain
  logic [dbg_pkg::ADDR_W-1:0] spr_addr;
  logic [dbg_pkg::DATA_W-1:0] spr_wdata;
  logic [dbg_pkg::DATA_W-1:0] spr_rdata;
  logic                       spr_stb;
  logic                       spr_we;
  logic                       spr_ack;

  dbg_burst_engine u_engine (
    .tck_i        (tck_i),
    .rst_i        (rst_i),
    .cmd_stb_i    (cmd_stb_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_wr_i     (cmd_wr_i),
    .cmd_len_i    (cmd_len_i),
    .wdata_i      (wdata_i),
    .busy_o       (busy_o),
    .word_done_o  (word_done_o),
    .done_o       (done_o),
    .rdata_o      (rdata_o),
    .rdata_stb_o  (rdata_stb_o),
    .biu_strobe_o (biu_strobe),
    .biu_addr_o   (biu_addr),
    .biu_data_o   (biu_wdata),
    .biu_rd_wrn_o (biu_rd_wrn),
    .biu_data_i   (biu_rdata),
    .biu_rdy_i    (biu_rdy)
  );

  dbg_spr_biu u_biu (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .data_i     (biu_wdata),
    .data_o     (biu_rdata),
    .addr_i     (biu_addr),
    .strobe_i   (biu_strobe),
    .rd_wrn_i   (biu_rd_wrn),
    .rdy_o      (biu_rdy),
    .cpu_clk_i  (cpu_clk_i),
    .cpu_addr_o (spr_addr),
    .cpu_data_i (spr_rdata),
    .cpu_data_o (spr_wdata),
    .cpu_stb_o  (spr_stb),
    .cpu_we_o   (spr_we),
    .cpu_ack_i  (spr_ack)
  );

  cpu_spr_file u_spr (
    .cpu_clk_i  (cpu_clk_i),
    .rst_i      (rst_i),
    .spr_addr_i (spr_addr),
    .spr_data_i (spr_wdata),
    .spr_data_o (spr_rdata),
    .spr_stb_i  (spr_stb),
    .spr_we_i   (spr_we),
    .spr_ack_o  (spr_ack)
  );

endmodule

/* tb/tb_dbg_spr_top.sv */
// Random-burst testbench for the debug-to-SPR path with a register-file model
`timescale 1ns/1ps

module tb_dbg_spr_top;

  localparam int ROUNDS      = 20;                        // Write, read-back, random read
  localparam int NUM_CMDS    = 1 + 8 + 2 + 3 * ROUNDS;    // Zero read, wait pairs, wrap pair
  localparam int TIMEOUT_CYC = NUM_CMDS * 16 * 60;        // Cpu cycles at worst case per word

  logic                        cpu_clk_i = 1'b0;
  logic                        tck_i     = 1'b0;
  logic                        rst_i;
  logic                        cmd_stb_i;
  logic [dbg_pkg::ADDR_W-1:0]  cmd_addr_i;
  logic                        cmd_wr_i;
  logic [dbg_pkg::LEN_W-1:0]   cmd_len_i;
  logic [dbg_pkg::DATA_W-1:0]  wdata_i;
  logic                        busy_o;
  logic                        word_done_o;
  logic                        done_o;
  logic [dbg_pkg::DATA_W-1:0]  rdata_o;
  logic                        rdata_stb_o;

  logic [dbg_pkg::DATA_W-1:0]  model [dbg_pkg::SPR_DEPTH];  // Mirror of the SPR file
  logic [15:0]                 lfsr_q;                       // Random source state
  int                          cycles     = 0;
  int                          done_total = 0;               // done_o pulses seen
  int                          cmds_run   = 0;

  dbg_spr_top uut (
    .tck_i       (tck_i),
    .cpu_clk_i   (cpu_clk_i),
    .rst_i       (rst_i),
    .cmd_stb_i   (cmd_stb_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_wr_i    (cmd_wr_i),
    .cmd_len_i   (cmd_len_i),
    .wdata_i     (wdata_i),
    .busy_o      (busy_o),
    .word_done_o (word_done_o),
    .done_o      (done_o),
    .rdata_o     (rdata_o),
    .rdata_stb_o (rdata_stb_o)
  );

  always #5  cpu_clk_i = ~cpu_clk_i;  // 10 ns
  always #13 tck_i     = ~tck_i;      // 26 ns and unrelated to cpu clock

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic fail_and_stop(input string line);
    $display("%s", line);
    $display("Finished with errors");
    $fatal(1, "simulation stopped on first failure");
  endtask

  // 16-bit Galois LFSR with taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Cycle budget for the whole run
  always @(posedge cpu_clk_i) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYC) begin
      fail_and_stop($sformatf("Timeout, the run did not finish within %0d cpu cycles",
                              TIMEOUT_CYC));
    end
  end

  always @(negedge tck_i) begin
    if (done_o) begin
      done_total++;  // Any stray done shows up at the end
    end
  end

  //////////////////////////////
  // One burst, driven and checked
  //////////////////////////////

  task automatic run_burst(input logic [dbg_pkg::ADDR_W-1:0] addr, input logic wr,
                           input logic [dbg_pkg::LEN_W-1:0] len, input logic stray);
    int                            words;
    int                            n_done;
    int                            n_rstb;
    logic [dbg_pkg::SPR_IDX_W-1:0] idx;
    logic                          poked;
    logic                          finished;
    logic [dbg_pkg::DATA_W-1:0]    word;

    words    = int'(len) + 1;  // Encoded n-1
    n_done   = 0;
    n_rstb   = 0;
    poked    = 1'b0;
    finished = 1'b0;
    word     = '0;
    cmds_run++;

    @(negedge tck_i);
    assert (!busy_o && !done_o && !word_done_o && !rdata_stb_o)
      else fail_and_stop($sformatf("[ERROR] %0t: engine not idle before command", $time));
    cmd_addr_i = addr;
    cmd_wr_i   = wr;
    cmd_len_i  = len;
    cmd_stb_i  = 1'b1;  // One tck cycle
    if (wr) begin
      word    = rand_bits(32);
      wdata_i = word;
    end

    while (!finished) begin
      @(negedge tck_i);
      cmd_stb_i = 1'b0;
      idx = addr[dbg_pkg::SPR_IDX_W-1:0] + n_done[dbg_pkg::SPR_IDX_W-1:0];  // Wraps at 64
      if (rdata_stb_o) begin
        assert (rdata_o === model[idx])
          else fail_and_stop($sformatf("[ERROR] %0t: SPR %0d read %h, expected %h",
                                       $time, idx, rdata_o, model[idx]));
        n_rstb++;
      end
      if (word_done_o) begin
        if (wr) begin
          model[idx] = word;        // Word taken by the engine
          word       = rand_bits(32);
          wdata_i    = word;        // Next word for the host
        end
        n_done++;
      end
      if (done_o) begin
        finished = 1'b1;
        assert (!busy_o)
          else fail_and_stop($sformatf("[ERROR] %0t: busy_o still high with done_o", $time));
      end else if (stray && !poked && busy_o) begin
        // Command while busy must be dropped
        cmd_addr_i = rand_bits(32);
        cmd_wr_i   = 1'b1;
        cmd_len_i  = '1;
        cmd_stb_i  = 1'b1;
        poked      = 1'b1;
      end
    end

    assert (n_done == words)
      else fail_and_stop($sformatf("[ERROR] %0t: %0d word_done pulses, expected %0d",
                                   $time, n_done, words));
    assert (n_rstb == (wr ? 0 : words))
      else fail_and_stop($sformatf("[ERROR] %0t: %0d rdata_stb pulses, expected %0d",
                                   $time, n_rstb, wr ? 0 : words));
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [dbg_pkg::ADDR_W-1:0] addr;
    logic [dbg_pkg::LEN_W-1:0]  len;
    logic                       stray;
    logic [31:0]                r;

    lfsr_q     = 16'd11055;
    rst_i      = 1'b1;
    cmd_stb_i  = 1'b0;
    cmd_addr_i = '0;
    cmd_wr_i   = 1'b0;
    cmd_len_i  = '0;
    wdata_i    = '0;
    model      = '{default: '0};  // SPRs clear on reset

    repeat (4) @(posedge cpu_clk_i);
    @(negedge cpu_clk_i);
    rst_i = 1'b0;

    run_burst('0, 1'b0, '1, 1'b0);  // 16 words of zero

    // Wait states 0..3 from address low bits
    for (int w = 0; w < 4; w++) begin
      addr = (rand_bits(30) << 2) | 32'(w);
      run_burst(addr, 1'b1, '0, 1'b0);
      run_burst(addr, 1'b0, '0, 1'b0);
    end

    // Index 60 through 11 wraps past the top
    addr = (rand_bits(26) << 6) | 32'd60;
    run_burst(addr, 1'b1, '1, 1'b0);
    run_burst(addr, 1'b0, '1, 1'b1);

    for (int n = 0; n < ROUNDS; n++) begin
      addr  = rand_bits(32);
      r     = rand_bits(dbg_pkg::LEN_W);
      len   = r[dbg_pkg::LEN_W-1:0];
      r     = rand_bits(1);
      stray = r[0];
      run_burst(addr, 1'b1, len, stray);
      run_burst(addr, 1'b0, len, 1'b0);   // Read-back
      addr  = rand_bits(32);
      r     = rand_bits(dbg_pkg::LEN_W);
      len   = r[dbg_pkg::LEN_W-1:0];
      run_burst(addr, 1'b0, len, stray);  // Anywhere in the file
    end

    @(negedge tck_i);
    assert (done_total == cmds_run)
      else fail_and_stop($sformatf("[ERROR] %0t: %0d done pulses for %0d commands",
                                   $time, done_total, cmds_run));

    $display("Finished with no errors");
    $finish;
  end

endmodule
